// ==== compile.f ====
+incdir+source
source/bus_pkg.sv
source/bus_if.sv
source/addr_decoder.sv
source/xfer_fsm.sv
source/response_timer.sv
source/reg_slave.sv
source/bus_top.sv
testbench/tb_clock.sv
testbench/bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bus interconnect testbench with Verilator and run it
# exits nonzero unless the testbench reports success

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module bus_tb \
	-f compile.f --Mdir obj_dir -o bus_sim \
	&& ./obj_dir/bus_sim | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

// ==== testbench/bus_tb.sv ====
// testbench for the bus interconnect top level
// a reference model of the four register files predicts every response
// at most 256 expected responses are kept, in request order
// slave 3 is only touched by the last test, it stays busy afterwards
// inputs change on the falling edge, the DUT samples on the rising edge
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_tb;
	import bus_pkg::*;

	localparam int          WAIT_LIMIT  = 64;
	localparam int          DRAIN_LIMIT = 2000;
	localparam logic [31:0] LFSR_SEED   = 32'h8782_2bc6;

	logic                i_clk;
	logic                i_reset;
	logic                i_req_valid;
	logic                o_req_ready;
	bus_op_e             i_req_op;
	logic [`BUS_AW-1:0]  i_req_addr;
	logic [`BUS_DW-1:0]  i_req_wdata;
	logic                o_rsp_valid;
	logic                i_rsp_ready;
	logic [`BUS_DW-1:0]  o_rsp_rdata;
	rsp_status_e         o_rsp_status;

	// reference register files, one row per slave
	logic [`BUS_DW-1:0]  ref_mem [`BUS_NS][`REGF_DEPTH];
	// expected responses, written at issue and read at the handshake
	logic [`BUS_DW-1:0]  exp_rdata [256];
	rsp_status_e         exp_status [256];
	int                  exp_count;
	int                  rsp_count;
	int                  errors;
	int                  tests_passed;
	int                  tests_failed;
	int                  errors_at_start;
	logic [31:0]         lfsr_state;
	logic [31:0]         bp_state;
	logic                backpressure;

	tb_clock #(.PERIOD_NS(100)) tb_clock_inst (.o_clk(i_clk));

	bus_top bus_top_inst (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_req_valid  (i_req_valid),
		.o_req_ready  (o_req_ready),
		.i_req_op     (i_req_op),
		.i_req_addr   (i_req_addr),
		.i_req_wdata  (i_req_wdata),
		.o_rsp_valid  (o_rsp_valid),
		.i_rsp_ready  (i_rsp_ready),
		.o_rsp_rdata  (o_rsp_rdata),
		.o_rsp_status (o_rsp_status)
	);

	//////////////////////////////////////////////////
	// response checking
	//////////////////////////////////////////////////

	// counts responses taken by the master
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			rsp_count <= 0;
		else if (o_rsp_valid && i_rsp_ready)
			rsp_count <= rsp_count + 1;
	end

	// every taken response matches the oldest expected one
	a_rsp_match: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rsp_valid && i_rsp_ready |-> o_rsp_rdata == exp_rdata[rsp_count[7:0]]
			&& o_rsp_status == exp_status[rsp_count[7:0]])
	else
	begin
		errors++;
		$display("FAILED at %0t: response %0d is %h %s, expected %h %s", $time, rsp_count,
			o_rsp_rdata, o_rsp_status.name(), exp_rdata[rsp_count[7:0]],
			exp_status[rsp_count[7:0]].name());
	end

	// no response without a request behind it
	a_rsp_known: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rsp_valid |-> rsp_count < exp_count)
	else
	begin
		errors++;
		$display("FAILED at %0t: response valid with no request outstanding", $time);
	end

	//////////////////////////////////////////////////
	// random numbers and reference model
	//////////////////////////////////////////////////

	// right-shift Galois LFSR, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8000_0057) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// slave 4 stands for any unmapped address
	task automatic rand_addr(input int slave, output logic [`BUS_AW-1:0] addr);
		logic [31:0] v;
		if (slave < 4)
		begin
			take_bits(12, v);
			addr = {4'(slave), v[11:0]};
		end
		else
		begin
			take_bits(16, v);
			addr = v[15:0];
			if (addr < 16'h4000)
				addr = addr | 16'h4000;
		end
	endtask

	// predicts one response and updates the model
	task automatic predict(input bus_op_e op, input logic [`BUS_AW-1:0] addr,
		input logic [`BUS_DW-1:0] wdata);
		int         slave;
		int         word;
		logic [7:0] slot;
		slave = int'(addr[15:12]);
		word  = int'(addr[5:2]);
		slot  = exp_count[7:0];
		exp_rdata[slot] = '0;
		// unmapped, or a write to read-only slave 2
		if (slave > 3 || (op == OP_WRITE && slave == 2))
			exp_status[slot] = RSP_DECERR;
		else if (slave == 3)
			exp_status[slot] = RSP_TIMEOUT;
		else
		begin
			exp_status[slot] = RSP_OKAY;
			if (op == OP_WRITE)
				ref_mem[slave][word] = wdata;
			else
				exp_rdata[slot] = ref_mem[slave][word];
		end
		exp_count++;
	endtask

	//////////////////////////////////////////////////
	// request driving and test bookkeeping
	//////////////////////////////////////////////////

	task automatic send_req(input bus_op_e op, input logic [`BUS_AW-1:0] addr,
		input logic [`BUS_DW-1:0] wdata);
		int waited;
		waited = 0;
		predict(op, addr, wdata);
		i_req_valid = 1'b1;
		i_req_op    = op;
		i_req_addr  = addr;
		i_req_wdata = wdata;
		// ready only moves on a rising edge, so it is settled here
		while (!o_req_ready && waited < WAIT_LIMIT)
		begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_req_ready)
		begin
			errors++;
			$display("request to %h was never accepted by the DUT", addr);
		end
		@(negedge i_clk);
		i_req_valid = 1'b0;
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		while (rsp_count != exp_count && waited < DRAIN_LIMIT)
		begin
			@(negedge i_clk);
			waited++;
		end
		if (rsp_count != exp_count)
		begin
			errors++;
			$display("timed out waiting for responses, got %0d of %0d", rsp_count, exp_count);
		end
	endtask

	task automatic end_test(input int num, input string name);
		drain_responses();
		if (errors == errors_at_start)
		begin
			tests_passed++;
			$display("test %0d %s: passed", num, name);
		end
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", num, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// response ready, randomly low under back-pressure
	initial
	begin
		i_rsp_ready = 1'b1;
		bp_state    = LFSR_SEED;
		forever
		begin
			@(negedge i_clk);
			if (backpressure)
			begin
				i_rsp_ready = bp_state[0];
				bp_state    = lfsr_next(bp_state);
			end
			else
				i_rsp_ready = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [31:0]        v;
		logic [`BUS_AW-1:0] addr;
		logic [`BUS_AW-1:0] written [$];
		bus_op_e            op;
		i_reset         = 1'b1;
		i_req_valid     = 1'b0;
		i_req_op        = OP_READ;
		i_req_addr      = '0;
		i_req_wdata     = '0;
		backpressure    = 1'b0;
		lfsr_state      = LFSR_SEED;
		exp_count       = 0;
		errors          = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		errors_at_start = 0;
		// slave s word w resets to ((s + 1) << 28) ^ w
		for (int s = 0; s < `BUS_NS; s++)
			for (int w = 0; w < `REGF_DEPTH; w++)
				ref_mem[s][w] = (32'(s + 1) << 28) ^ 32'(w);
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;

		// every word of slaves 0 to 2
		for (int s = 0; s < 3; s++)
			for (int w = 0; w < `REGF_DEPTH; w++)
				send_req(OP_READ, {4'(s), 6'd0, 4'(w), 2'd0}, '0);
		end_test(1, "reset values");

		for (int n = 0; n < 16; n++)
		begin
			take_bits(1, v);
			rand_addr(int'(v[0]), addr);
			take_bits(32, v);
			send_req(OP_WRITE, addr, v);
			written.push_back(addr);
		end
		foreach (written[n])
			send_req(OP_READ, written[n], '0);
		end_test(2, "write then read");

		// refused writes leave slave 2 unchanged
		for (int n = 0; n < 4; n++)
		begin
			rand_addr(2, addr);
			take_bits(32, v);
			send_req(OP_WRITE, addr, v);
			send_req(OP_READ, addr, '0);
		end
		for (int n = 0; n < 4; n++)
		begin
			rand_addr(4, addr);
			take_bits(32, v);
			send_req(n < 2 ? OP_READ : OP_WRITE, addr, v);
		end
		end_test(3, "write protection");

		// slave pick 3 maps to an unmapped address here
		backpressure = 1'b1;
		for (int n = 0; n < 40; n++)
		begin
			take_bits(2, v);
			rand_addr(v[1:0] == 2'd3 ? 4 : int'(v[1:0]), addr);
			take_bits(1, v);
			op = bus_op_e'(v[0]);
			take_bits(32, v);
			send_req(op, addr, v);
		end
		drain_responses();
		backpressure = 1'b0;
		end_test(4, "back-pressure");

		rand_addr(3, addr);
		send_req(OP_READ, addr, '0);
		end_test(5, "timeout");

		$display("tests passed %0d, failed %0d, check errors %0d", tests_passed,
			tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== testbench/tb_clock.sv ====
// free-running testbench clock, starts low
// the first rising edge comes half a period after time zero
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	initial
		o_clk = 1'b0;

	// half period high, half period low
	always
		#(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// ==== source/bus_top.sv ====
// single-master interconnect top level
// decoder buffers one request while the FSM serves another
// the address map and slave set are fixed by the configuration header
// slave 3 never answers inside the timeout and stays busy for a while
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_top (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// request channel
	input  logic                  i_req_valid,
	output logic                  o_req_ready,
	input  bus_pkg::bus_op_e      i_req_op,
	input  logic [`BUS_AW-1:0]    i_req_addr,
	input  logic [`BUS_DW-1:0]    i_req_wdata,
	// response channel
	output logic                  o_rsp_valid,
	input  logic                  i_rsp_ready,
	output logic [`BUS_DW-1:0]    o_rsp_rdata,
	output bus_pkg::rsp_status_e  o_rsp_status
);

	localparam int SLV_LAT [`BUS_NS] = '{
		`SLV0_LAT, `SLV1_LAT, `SLV2_LAT, `SLV3_LAT
	};
	localparam logic [`BUS_NS-1:0] SLV_WR = `SLV_WRITE_ALLOWED;

	logic timer_en;
	logic timeout;

	dec_if dec_bus ();
	slv_if slv_bus [`BUS_NS] ();

	addr_decoder addr_decoder_inst (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_valid (i_req_valid),
		.o_ready (o_req_ready),
		.i_op    (i_req_op),
		.i_addr  (i_req_addr),
		.i_wdata (i_req_wdata),
		.o_dec   (dec_bus)
	);

	xfer_fsm xfer_fsm_inst (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_dec        (dec_bus),
		.o_slv0       (slv_bus[0]),
		.o_slv1       (slv_bus[1]),
		.o_slv2       (slv_bus[2]),
		.o_slv3       (slv_bus[3]),
		.o_timer_en   (timer_en),
		.i_timeout    (timeout),
		.o_rsp_valid  (o_rsp_valid),
		.i_rsp_ready  (i_rsp_ready),
		.o_rsp_rdata  (o_rsp_rdata),
		.o_rsp_status (o_rsp_status)
	);

	response_timer response_timer_inst (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_enable  (timer_en),
		.o_expired (timeout)
	);

	// slave k resets its words from 32'h1000_0000 * (k + 1)
	for (genvar k = 0; k < `BUS_NS; k++)
	begin : g_slave
		reg_slave #(
			.LATENCY       (SLV_LAT[k]),
			.WRITABLE      (SLV_WR[k]),
			.RESET_PATTERN (32'h1000_0000 * (k + 1))
		) reg_slave_inst (
			.i_clk   (i_clk),
			.i_reset (i_reset),
			.i_bus   (slv_bus[k])
		);
	end

endmodule

// ==== source/reg_slave.sv ====
// register-file slave with a fixed acknowledge latency
// a strobe arriving while a countdown runs is ignored
// WRITABLE clear makes writes acknowledge without updating the word
// read data is the word as it was before a same-access write
`timescale 1ns/1ps
`include "bus_cfg.svh"

module reg_slave #(
	parameter int                  LATENCY       = 1,
	parameter bit                  WRITABLE      = 1'b1,
	parameter logic [`BUS_DW-1:0]  RESET_PATTERN = '0
) (
	input  logic i_clk,
	input  logic i_reset,
	slv_if.slv   i_bus
);
	import bus_pkg::*;

	// room for LATENCY and the compare against 2
	localparam int CW = $clog2(LATENCY + 2);
	localparam int IW = $clog2(`REGF_DEPTH);

	logic [`BUS_DW-1:0]  mem [`REGF_DEPTH];
	logic [CW-1:0]       cnt;
	logic                start;
	logic                done;
	logic [IW-1:0]       idx_q;
	bus_op_e             op_q;
	logic [`BUS_DW-1:0]  wdata_q;
	logic [IW-1:0]       idx;
	bus_op_e             op;
	logic [`BUS_DW-1:0]  wdata;

	// cnt is nonzero from the strobe through the ack cycle
	assign start = i_bus.strb && (cnt == '0);
	// done fires on the edge before the ack cycle
	assign done  = start ? (LATENCY == 1) : (cnt == CW'(2));

	// latency 1 completes on the strobe edge itself
	assign idx   = start ? i_bus.addr[IW+1:2] : idx_q;
	assign op    = start ? i_bus.op : op_q;
	assign wdata = start ? i_bus.wdata : wdata_q;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			cnt       <= '0;
			i_bus.ack <= 1'b0;
		end
		else
		begin
			i_bus.ack <= done;
			if (start)
				cnt <= CW'(LATENCY);
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
		end
	end

	// captured request for multi-cycle latencies
	always_ff @(posedge i_clk)
	begin
		if (start)
		begin
			idx_q   <= i_bus.addr[IW+1:2];
			op_q    <= i_bus.op;
			wdata_q <= i_bus.wdata;
		end
	end

	// word k resets to the pattern xor its index
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int k = 0; k < `REGF_DEPTH; k++)
				mem[k] <= RESET_PATTERN ^ `BUS_DW'(k);
		end
		else if (done && WRITABLE && op == OP_WRITE)
			mem[idx] <= wdata;
	end

	always_ff @(posedge i_clk)
	begin
		if (done)
			i_bus.rdata <= mem[idx];
	end

	a_ack_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_bus.ack |-> cnt != '0);

endmodule

// ==== source/response_timer.sv ====
// wait-cycle counter for the transfer FSM
// clears whenever disabled, saturates at XFER_TIMEOUT
`timescale 1ns/1ps
`include "bus_cfg.svh"

module response_timer (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_enable,
	output logic o_expired
);

	localparam int TW = $clog2(`XFER_TIMEOUT + 1);

	logic [TW-1:0] count;

	// counts cycles spent in ST_WAIT
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_enable)
			count <= '0;
		else if (!o_expired)
			count <= count + 1'b1;
	end

	// high from the cycle the count reaches the bound
	assign o_expired = (count == TW'(`XFER_TIMEOUT));

endmodule

// ==== source/xfer_fsm.sv ====
// transfer FSM, serves one decoded request at a time
// strobes only the decoded slave and waits for its ack or the timer
// late acks outside ST_WAIT are dropped, write responses carry zero data
`timescale 1ns/1ps
`include "bus_cfg.svh"

module xfer_fsm (
	input  logic                    i_clk,
	input  logic                    i_reset,
	dec_if.snk                      i_dec,
	slv_if.mst                      o_slv0,
	slv_if.mst                      o_slv1,
	slv_if.mst                      o_slv2,
	slv_if.mst                      o_slv3,
	output logic                    o_timer_en,
	input  logic                    i_timeout,
	output logic                    o_rsp_valid,
	input  logic                    i_rsp_ready,
	output logic [`BUS_DW-1:0]      o_rsp_rdata,
	output bus_pkg::rsp_status_e    o_rsp_status
);
	import bus_pkg::*;

	xfer_state_e         state;
	logic [`BUS_NS-1:0]  strb_q;
	logic [`BUS_NS-1:0]  sel_q;
	bus_op_e             op_q;
	logic [`BUS_AW-1:0]  addr_q;
	logic [`BUS_DW-1:0]  wdata_q;
	logic [`BUS_NS-1:0]  ack_vec;
	logic [`BUS_DW-1:0]  rdata_arr [`BUS_NS];
	logic [`BUS_DW-1:0]  sel_rdata;
	logic                take;
	logic                sel_ack;

	//////////////////////////////////////////////////
	// slave fan-out and return select
	//////////////////////////////////////////////////

	// one shared request payload, strobe picks the target
	assign o_slv0.strb  = strb_q[0];
	assign o_slv1.strb  = strb_q[1];
	assign o_slv2.strb  = strb_q[2];
	assign o_slv3.strb  = strb_q[3];
	assign o_slv0.op    = op_q;
	assign o_slv1.op    = op_q;
	assign o_slv2.op    = op_q;
	assign o_slv3.op    = op_q;
	assign o_slv0.addr  = addr_q;
	assign o_slv1.addr  = addr_q;
	assign o_slv2.addr  = addr_q;
	assign o_slv3.addr  = addr_q;
	assign o_slv0.wdata = wdata_q;
	assign o_slv1.wdata = wdata_q;
	assign o_slv2.wdata = wdata_q;
	assign o_slv3.wdata = wdata_q;

	assign ack_vec      = {o_slv3.ack, o_slv2.ack, o_slv1.ack, o_slv0.ack};
	assign rdata_arr[0] = o_slv0.rdata;
	assign rdata_arr[1] = o_slv1.rdata;
	assign rdata_arr[2] = o_slv2.rdata;
	assign rdata_arr[3] = o_slv3.rdata;

	// an ack from any other slave is stale
	assign sel_ack = |(ack_vec & sel_q);

	always_comb
	begin
		sel_rdata = '0;
		for (int k = 0; k < `BUS_NS; k++)
			if (sel_q[k])
				sel_rdata = rdata_arr[k];
	end

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	assign i_dec.ready = (state == ST_IDLE);
	assign take        = i_dec.valid && i_dec.ready;
	assign o_timer_en  = (state == ST_WAIT);
	assign o_rsp_valid = (state == ST_RESPOND);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state  <= ST_IDLE;
			strb_q <= '0;
			sel_q  <= '0;
		end
		else
		begin
			// strobe lasts one cycle
			strb_q <= '0;
			case (state)
				ST_IDLE:
					if (take)
					begin
						if (i_dec.decode[`BUS_NS])
							state <= ST_RESPOND;
						else
						begin
							state  <= ST_WAIT;
							strb_q <= i_dec.decode[`BUS_NS-1:0];
							sel_q  <= i_dec.decode[`BUS_NS-1:0];
						end
					end
				ST_WAIT:
					if (sel_ack || i_timeout)
						state <= ST_RESPOND;
				ST_RESPOND:
					if (i_rsp_ready)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge i_clk)
	begin
		if (take)
		begin
			op_q    <= i_dec.op;
			addr_q  <= i_dec.addr;
			wdata_q <= i_dec.wdata;
		end
		if (take && i_dec.decode[`BUS_NS])
		begin
			o_rsp_status <= RSP_DECERR;
			o_rsp_rdata  <= '0;
		end
		else if (state == ST_WAIT && sel_ack)
		begin
			// ack wins over a timeout in the same cycle
			o_rsp_status <= RSP_OKAY;
			o_rsp_rdata  <= (op_q == OP_READ) ? sel_rdata : '0;
		end
		else if (state == ST_WAIT && i_timeout)
		begin
			o_rsp_status <= RSP_TIMEOUT;
			o_rsp_rdata  <= '0;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_one_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0(strb_q));

	a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_rdata)
			&& $stable(o_rsp_status));

endmodule

// ==== source/addr_decoder.sv ====
// registered address decoder, one request of buffering
// output appears one cycle after acceptance and holds under a stall
// writes to a read-only region decode as no slave
`timescale 1ns/1ps
`include "bus_cfg.svh"

module addr_decoder (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_valid,
	output logic                o_ready,
	input  bus_pkg::bus_op_e    i_op,
	input  logic [`BUS_AW-1:0]  i_addr,
	input  logic [`BUS_DW-1:0]  i_wdata,
	dec_if.src                  o_dec
);
	import bus_pkg::*;

	localparam logic [`BUS_AW-1:0] SLV_BASE [`BUS_NS] = '{
		`SLV0_BASE, `SLV1_BASE, `SLV2_BASE, `SLV3_BASE
	};
	localparam logic [`BUS_NS-1:0] WR_OK = `SLV_WRITE_ALLOWED;

	logic [`BUS_NS-1:0] hit;
	logic [`BUS_NS:0]   request;

	//////////////////////////////////////////////////
	// region match
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int k = 0; k < `BUS_NS; k++)
		begin
			hit[k] = ((i_addr ^ SLV_BASE[k]) & `SLV_MASK) == '0;
			// refused write counts as a miss
			if (i_op == OP_WRITE && !WR_OK[k])
				hit[k] = 1'b0;
		end
		// regions do not overlap, so at most one hit
		request = {~|hit, hit};
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	// stall only when holding something not yet taken
	assign o_ready = !o_dec.valid || o_dec.ready;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_dec.valid  <= 1'b0;
			o_dec.decode <= '0;
		end
		else if (o_ready)
		begin
			o_dec.valid  <= i_valid;
			// decode stays zero while nothing is held
			o_dec.decode <= i_valid ? request : '0;
		end
	end

	// payload, loaded only with a new request
	always_ff @(posedge i_clk)
	begin
		if (o_ready && i_valid)
		begin
			o_dec.op    <= i_op;
			o_dec.addr  <= i_addr;
			o_dec.wdata <= i_wdata;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_decode_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		o_dec.valid |-> $onehot(o_dec.decode));

	a_decode_idle_zero: assert property (@(posedge i_clk) disable iff (i_reset)
		!o_dec.valid |-> o_dec.decode == '0);

	// consumer must see a frozen request until it takes it
	a_stall_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		o_dec.valid && !o_dec.ready |=> o_dec.valid && $stable(o_dec.decode)
			&& $stable(o_dec.op) && $stable(o_dec.addr) && $stable(o_dec.wdata));

endmodule

// ==== source/bus_if.sv ====
// decoded-request and slave-port interfaces
// dec_if follows valid/ready, payload holds while valid and not ready
// slv_if strb and ack are single-cycle pulses, rdata is only valid with ack
`timescale 1ns/1ps
`include "bus_cfg.svh"

interface dec_if;
	import bus_pkg::*;

	logic                valid;
	logic                ready;
	bus_op_e             op;
	logic [`BUS_AW-1:0]  addr;
	logic [`BUS_DW-1:0]  wdata;
	// one bit per slave, top bit flags an unmapped or refused access
	logic [`BUS_NS:0]    decode;

	modport src (output valid, output op, output addr, output wdata, output decode,
		input ready);
	modport snk (input valid, input op, input addr, input wdata, input decode,
		output ready);
endinterface

interface slv_if;
	import bus_pkg::*;

	logic                strb;
	bus_op_e             op;
	logic [`BUS_AW-1:0]  addr;
	logic [`BUS_DW-1:0]  wdata;
	logic                ack;
	logic [`BUS_DW-1:0]  rdata;

	// master side sits in the transfer FSM
	modport mst (output strb, output op, output addr, output wdata,
		input ack, input rdata);
	modport slv (input strb, input op, input addr, input wdata,
		output ack, output rdata);
endinterface

// ==== source/bus_pkg.sv ====
// shared types for the bus interconnect
// widths and the address map live in the configuration header
package bus_pkg;

	// request opcode
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// response status returned to the master
	typedef enum logic [1:0] {
		RSP_OKAY    = 2'd0,
		RSP_DECERR  = 2'd1,
		RSP_TIMEOUT = 2'd2
	} rsp_status_e;

	// transfer FSM states
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_WAIT    = 2'd1,
		ST_RESPOND = 2'd2
	} xfer_state_e;

endpackage

// ==== source/bus_cfg.svh ====
// bus interconnect configuration
// the address map is fixed here, regions are matched on the top 4 address bits
// slave 3 latency is deliberately longer than the transfer timeout
// register file index comes from address bits 5:2, so REGF_DEPTH must stay 16
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// bus widths
`define BUS_AW 16
`define BUS_DW 32
`define BUS_NS 4

// slave regions, compared under SLV_MASK
`define SLV0_BASE 16'h0000
`define SLV1_BASE 16'h1000
`define SLV2_BASE 16'h2000
`define SLV3_BASE 16'h3000
`define SLV_MASK 16'hF000

// one bit per slave, slave 2 is read-only
`define SLV_WRITE_ALLOWED 4'b1011

// acknowledge latency in cycles after the strobe
`define SLV0_LAT 1
`define SLV1_LAT 3
`define SLV2_LAT 2
`define SLV3_LAT 24

// wait bound in ST_WAIT before a timeout response
`define XFER_TIMEOUT 16

// words per register-file slave
`define REGF_DEPTH 16

`endif
